// File: ecfg_top.f
source/ecfg_pkg.sv
source/ecfg_link_regs.sv
source/ecfg_io_regs.sv
source/ecfg_readback.sv
source/ecfg_top.sv
test/ecfg_tb.sv

// File: Bender.yml
package:
  name: ecfg

sources:
  # package first, then the register groups and the top level
  - source/ecfg_pkg.sv
  - source/ecfg_link_regs.sv
  - source/ecfg_io_regs.sv
  - source/ecfg_readback.sv
  - source/ecfg_top.sv

  - target: test
    files:
      - test/ecfg_tb.sv

// File: test/ecfg_tb.sv
`default_nettype none

module ecfg_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int                  IDW         = 12;
   localparam int                  RFAW        = 12;
   localparam logic [IDW-1:0]      DEF_COREID  = 12'h808;
   localparam ecfg_pkg::cfg_word_t VERSION     = 32'h0102_0304;
   localparam int                  HALF_PERIOD = 50;
   localparam int                  N_RANDOM    = 40;    // words per writable register
   localparam int                  TIMEOUT     = 2000;  // about 650 cycles of stimulus

   logic                mi_clk = 1'b0;
   logic                hw_reset;
   logic                mi_en;
   logic                mi_we;
   logic [RFAW-1:0]     mi_addr;
   ecfg_pkg::cfg_word_t mi_din;
   ecfg_pkg::gpio_t     ecfg_datain;
   ecfg_pkg::cfg_word_t mi_dout;
   logic                ecfg_sw_reset, ecfg_reset;
   logic                ecfg_tx_enable, ecfg_tx_mmu_mode, ecfg_tx_gpio_mode;
   ecfg_pkg::nibble_t   ecfg_tx_ctrl_mode, ecfg_tx_clkdiv;
   logic                ecfg_rx_enable, ecfg_rx_mmu_mode;
   logic                ecfg_rx_gpio_mode, ecfg_rx_loopback_mode;
   logic                ecfg_cclk_en;
   ecfg_pkg::nibble_t   ecfg_cclk_div, ecfg_cclk_pllcfg;
   logic [IDW-1:0]      ecfg_coreid;
   ecfg_pkg::gpio_t     ecfg_dataout;

   // shadow registers, masked to field width
   logic                sh_reset;
   ecfg_pkg::cfgtx_t    sh_cfgtx;
   ecfg_pkg::cfgrx_t    sh_cfgrx;
   ecfg_pkg::cfgclk_t   sh_cfgclk;
   logic [IDW-1:0]      sh_coreid;
   ecfg_pkg::gpio_t     sh_dataout;

   ecfg_pkg::cfg_word_t rd_expect;   // mi_dout due after the last read edge
   logic [31:0]         rng_state;
   int                  cycle_count = 0;
   int                  writable [6] = '{ecfg_pkg::REG_SYSRESET, ecfg_pkg::REG_SYSCFGTX,
                                         ecfg_pkg::REG_SYSCFGRX, ecfg_pkg::REG_SYSCFGCLK,
                                         ecfg_pkg::REG_SYSCOREID, ecfg_pkg::REG_SYSDATAOUT};

   ecfg_top #(
      .E_VERSION (VERSION)
   ) UUT (.*);

   always #HALF_PERIOD mi_clk = ~mi_clk;

   always @(posedge mi_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT) begin
         stop_on_failure("run did not finish within the cycle limit");
      end
   end

   // ########################################################################
   // failure reporting and helpers
   // ########################################################################
   task automatic stop_on_failure(input string reason);
      $display("%s", reason);
      $display("Test failures found");
      $fatal(1, "stopped at first failure");
   endtask

   task automatic mismatch(input string name, input logic [31:0] expv, input logic [31:0] actv);
      stop_on_failure($sformatf("MISMATCH at %0t: %s expected %h, got %h",
                                $time, name, expv, actv));
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] s;
      s = x ^ (x << 13);
      s = s ^ (s >> 17);
      return s ^ (s << 5);
   endfunction

   // register contents as the host should read them
   function automatic ecfg_pkg::cfg_word_t reg_expect(input int idx);
      case (idx)
         ecfg_pkg::REG_SYSRESET:   return 32'(sh_reset);
         ecfg_pkg::REG_SYSCFGTX:   return 32'(sh_cfgtx);
         ecfg_pkg::REG_SYSCFGRX:   return 32'(sh_cfgrx);
         ecfg_pkg::REG_SYSCFGCLK:  return 32'(sh_cfgclk);
         ecfg_pkg::REG_SYSCOREID:  return 32'(sh_coreid);
         ecfg_pkg::REG_SYSVERSION: return VERSION;
         ecfg_pkg::REG_SYSDATAIN:  return 32'(ecfg_datain);  // held for 2+ cycles
         ecfg_pkg::REG_SYSDATAOUT: return 32'(sh_dataout);
         default:                  return '0;
      endcase
   endfunction

   task automatic clear_shadow();
      sh_reset   = 1'b0;
      sh_cfgtx   = '0;
      sh_cfgrx   = '0;
      sh_cfgclk  = '0;
      sh_coreid  = DEF_COREID;
      sh_dataout = '0;
   endtask

   // ########################################################################
   // host port tasks, inputs change on the falling edge
   // ########################################################################
   task automatic write_reg(input int idx, input logic [31:0] data);
      @(negedge mi_clk);
      mi_en   = 1'b1;
      mi_we   = 1'b1;
      mi_addr = RFAW'(idx * 4);
      mi_din  = data;
      @(posedge mi_clk);
      case (idx)
         ecfg_pkg::REG_SYSRESET:   sh_reset   = data[0];
         ecfg_pkg::REG_SYSCFGTX:   sh_cfgtx   = ecfg_pkg::cfgtx_t'(data);
         ecfg_pkg::REG_SYSCFGRX:   sh_cfgrx   = ecfg_pkg::cfgrx_t'(data);
         ecfg_pkg::REG_SYSCFGCLK:  sh_cfgclk  = ecfg_pkg::cfgclk_t'(data);
         ecfg_pkg::REG_SYSCOREID:  sh_coreid  = data[IDW-1:0];
         ecfg_pkg::REG_SYSDATAOUT: sh_dataout = ecfg_pkg::gpio_t'(data);
         default:                  ;  // read only or unmapped
      endcase
   endtask

   task automatic read_reg(input int idx);
      ecfg_pkg::cfg_word_t expv;
      @(negedge mi_clk);
      mi_en   = 1'b1;
      mi_we   = 1'b0;
      mi_addr = RFAW'(idx * 4);
      expv    = reg_expect(idx);
      @(posedge mi_clk);
      rd_expect = expv;  // checked at the next rising edge
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(negedge mi_clk);
         mi_en = 1'b0;
      end
   endtask

   task automatic pulse_hw_reset();
      @(negedge mi_clk);
      mi_en    = 1'b0;
      hw_reset = 1'b1;
      @(negedge mi_clk);
      hw_reset = 1'b0;
      clear_shadow();
   endtask

   // ########################################################################
   // checks
   // ########################################################################
   property follows(act, expv);
      @(posedge mi_clk) disable iff (hw_reset) act == expv;
   endproperty

   sw_rst_chk: assert property (follows(ecfg_sw_reset, sh_reset))
      else mismatch("ecfg_sw_reset", $sampled(sh_reset), $sampled(ecfg_sw_reset));
   rst_chk: assert property (follows(ecfg_reset, sh_reset))
      else mismatch("ecfg_reset", $sampled(sh_reset), $sampled(ecfg_reset));
   hw_rst_chk: assert property (@(posedge mi_clk) hw_reset |-> ecfg_reset)
      else mismatch("ecfg_reset", 1, $sampled(ecfg_reset));
   tx_en_chk: assert property (follows(ecfg_tx_enable, sh_cfgtx[0]))
      else mismatch("ecfg_tx_enable", $sampled(sh_cfgtx[0]), $sampled(ecfg_tx_enable));
   tx_mmu_chk: assert property (follows(ecfg_tx_mmu_mode, sh_cfgtx[1]))
      else mismatch("ecfg_tx_mmu_mode", $sampled(sh_cfgtx[1]), $sampled(ecfg_tx_mmu_mode));
   tx_gpio_chk: assert property (follows(ecfg_tx_gpio_mode, sh_cfgtx[3:2] == 2'b01))
      else mismatch("ecfg_tx_gpio_mode", $sampled(sh_cfgtx[3:2] == 2'b01),
                    $sampled(ecfg_tx_gpio_mode));
   tx_ctrl_chk: assert property (follows(ecfg_tx_ctrl_mode, sh_cfgtx[7:4]))
      else mismatch("ecfg_tx_ctrl_mode", $sampled(sh_cfgtx[7:4]), $sampled(ecfg_tx_ctrl_mode));
   tx_div_chk: assert property (follows(ecfg_tx_clkdiv, sh_cfgtx[11:8]))
      else mismatch("ecfg_tx_clkdiv", $sampled(sh_cfgtx[11:8]), $sampled(ecfg_tx_clkdiv));
   rx_en_chk: assert property (follows(ecfg_rx_enable, sh_cfgrx[0]))
      else mismatch("ecfg_rx_enable", $sampled(sh_cfgrx[0]), $sampled(ecfg_rx_enable));
   rx_mmu_chk: assert property (follows(ecfg_rx_mmu_mode, sh_cfgrx[1]))
      else mismatch("ecfg_rx_mmu_mode", $sampled(sh_cfgrx[1]), $sampled(ecfg_rx_mmu_mode));
   rx_gpio_chk: assert property (follows(ecfg_rx_gpio_mode, sh_cfgrx[3:2] == 2'b01))
      else mismatch("ecfg_rx_gpio_mode", $sampled(sh_cfgrx[3:2] == 2'b01),
                    $sampled(ecfg_rx_gpio_mode));
   rx_loop_chk: assert property (follows(ecfg_rx_loopback_mode, sh_cfgrx[3:2] == 2'b10))
      else mismatch("ecfg_rx_loopback_mode", $sampled(sh_cfgrx[3:2] == 2'b10),
                    $sampled(ecfg_rx_loopback_mode));
   cclk_en_chk: assert property (follows(ecfg_cclk_en, sh_cfgclk[3:0] != 4'h0))
      else mismatch("ecfg_cclk_en", $sampled(sh_cfgclk[3:0] != 4'h0), $sampled(ecfg_cclk_en));
   cclk_div_chk: assert property (follows(ecfg_cclk_div, sh_cfgclk[3:0]))
      else mismatch("ecfg_cclk_div", $sampled(sh_cfgclk[3:0]), $sampled(ecfg_cclk_div));
   pll_chk: assert property (follows(ecfg_cclk_pllcfg, sh_cfgclk[7:4]))
      else mismatch("ecfg_cclk_pllcfg", $sampled(sh_cfgclk[7:4]), $sampled(ecfg_cclk_pllcfg));
   coreid_chk: assert property (follows(ecfg_coreid, sh_coreid))
      else mismatch("ecfg_coreid", $sampled(sh_coreid), $sampled(ecfg_coreid));
   dataout_chk: assert property (follows(ecfg_dataout, sh_dataout))
      else mismatch("ecfg_dataout", $sampled(sh_dataout), $sampled(ecfg_dataout));

   // readback, one cycle behind the strobe, held otherwise
   dout_chk: assert property (@(posedge mi_clk) disable iff (hw_reset)
      (mi_en && !mi_we) |=> mi_dout == rd_expect)
      else mismatch("mi_dout", $sampled(rd_expect), $sampled(mi_dout));
   hold_chk: assert property (@(posedge mi_clk) disable iff (hw_reset)
      !(mi_en && !mi_we) |=> $stable(mi_dout))
      else stop_on_failure("mi_dout changed in a cycle without a read strobe");

   // ########################################################################
   // stimulus
   // ########################################################################
   initial begin
      hw_reset    = 1'b1;
      mi_en       = 1'b0;
      mi_we       = 1'b0;
      mi_addr     = '0;
      mi_din      = '0;
      ecfg_datain = '0;
      rd_expect   = '0;
      rng_state   = 32'h99dfe0ca;
      clear_shadow();
      repeat (4) @(negedge mi_clk);
      hw_reset = 1'b0;

      // reset values of every register
      for (int idx = 0; idx < 8; idx++) read_reg(idx);

      // random write then readback
      foreach (writable[i]) begin
         repeat (N_RANDOM) begin
            rng_state = xorshift32(rng_state);
            write_reg(writable[i], rng_state);
            read_reg(writable[i]);
         end
      end
      idle(2);

      // software reset, then a hw reset on top of it
      write_reg(ecfg_pkg::REG_SYSRESET, 32'h1);
      idle(1);
      write_reg(ecfg_pkg::REG_SYSRESET, 32'h0);
      idle(1);
      write_reg(ecfg_pkg::REG_SYSRESET, 32'hffff_ffff);
      pulse_hw_reset();
      idle(1);
      read_reg(ecfg_pkg::REG_SYSRESET);

      // pin sampling, input held two cycles before each read
      repeat (20) begin
         rng_state = xorshift32(rng_state);
         @(negedge mi_clk);
         mi_en       = 1'b0;
         ecfg_datain = ecfg_pkg::gpio_t'(rng_state);
         idle(1);
         read_reg(ecfg_pkg::REG_SYSDATAIN);
      end
      for (int idx = 8; idx < 16; idx++) read_reg(idx);  // unmapped
      idle(3);

      // port disabled, nothing may change
      for (int k = 0; k < 32; k++) begin
         rng_state = xorshift32(rng_state);
         @(negedge mi_clk);
         mi_en   = 1'b0;
         mi_we   = (k < 16) | rng_state[0];  // first pass writes every index
         mi_addr = RFAW'((k % 8) * 4) | RFAW'(rng_state[1:0]);
         mi_din  = (k < 16) ? ~reg_expect(k % 8) : xorshift32(rng_state);
      end
      for (int idx = 0; idx < 8; idx++) read_reg(idx);
      idle(3);

      $display("All tests passed!");
      $finish;
   end

endmodule

`default_nettype wire

// File: source/ecfg_top.sv
`default_nettype none

module ecfg_top #(
   parameter ecfg_pkg::cfg_word_t E_VERSION  = 32'h0000_0000,  // gen:plat:type:rev
   parameter int                  IDW        = 12,
   parameter int                  RFAW       = 12,
   parameter logic [IDW-1:0]      DEF_COREID = 12'h808
) (
   // host memory port
   input  wire                      mi_clk,
   input  wire                      hw_reset,
   input  wire                      mi_en,
   input  wire                      mi_we,             // full words only
   input  wire [RFAW-1:0]           mi_addr,           // byte address
   input  wire ecfg_pkg::cfg_word_t mi_din,
   input  wire ecfg_pkg::gpio_t     ecfg_datain,
   output ecfg_pkg::cfg_word_t      mi_dout,
   // reset
   output logic                     ecfg_sw_reset,
   output logic                     ecfg_reset,
   // tx
   output logic                     ecfg_tx_enable,
   output logic                     ecfg_tx_mmu_mode,
   output logic                     ecfg_tx_gpio_mode,
   output ecfg_pkg::nibble_t        ecfg_tx_ctrl_mode,
   output ecfg_pkg::nibble_t        ecfg_tx_clkdiv,
   // rx
   output logic                     ecfg_rx_enable,
   output logic                     ecfg_rx_mmu_mode,
   output logic                     ecfg_rx_gpio_mode,
   output logic                     ecfg_rx_loopback_mode,
   // cclk
   output logic                     ecfg_cclk_en,
   output ecfg_pkg::nibble_t        ecfg_cclk_div,
   output ecfg_pkg::nibble_t        ecfg_cclk_pllcfg,
   // id and pins
   output logic [IDW-1:0]           ecfg_coreid,
   output ecfg_pkg::gpio_t          ecfg_dataout
);

   // raw register contents for readback
   ecfg_pkg::cfgtx_t  cfgtx;
   ecfg_pkg::cfgrx_t  cfgrx;
   ecfg_pkg::cfgclk_t cfgclk;
   ecfg_pkg::gpio_t   datain_q;

   // ########################################################################
   // link group: reset, tx, rx
   // ########################################################################
   ecfg_link_regs #(
      .RFAW (RFAW)
   ) u_link_regs (
      .mi_clk                (mi_clk),
      .hw_reset              (hw_reset),
      .mi_en                 (mi_en),
      .mi_we                 (mi_we),
      .mi_addr               (mi_addr),
      .mi_din                (mi_din),
      .ecfg_sw_reset         (ecfg_sw_reset),
      .ecfg_reset            (ecfg_reset),
      .ecfg_tx_enable        (ecfg_tx_enable),
      .ecfg_tx_mmu_mode      (ecfg_tx_mmu_mode),
      .ecfg_tx_gpio_mode     (ecfg_tx_gpio_mode),
      .ecfg_tx_ctrl_mode     (ecfg_tx_ctrl_mode),
      .ecfg_tx_clkdiv        (ecfg_tx_clkdiv),
      .ecfg_rx_enable        (ecfg_rx_enable),
      .ecfg_rx_mmu_mode      (ecfg_rx_mmu_mode),
      .ecfg_rx_gpio_mode     (ecfg_rx_gpio_mode),
      .ecfg_rx_loopback_mode (ecfg_rx_loopback_mode),
      .cfgtx                 (cfgtx),
      .cfgrx                 (cfgrx)
   );

   // ########################################################################
   // io group: clock, core id, pins
   // ########################################################################
   ecfg_io_regs #(
      .RFAW       (RFAW),
      .IDW        (IDW),
      .DEF_COREID (DEF_COREID)
   ) u_io_regs (
      .mi_clk           (mi_clk),
      .hw_reset         (hw_reset),
      .mi_en            (mi_en),
      .mi_we            (mi_we),
      .mi_addr          (mi_addr),
      .mi_din           (mi_din),
      .ecfg_datain      (ecfg_datain),
      .ecfg_cclk_en     (ecfg_cclk_en),
      .ecfg_cclk_div    (ecfg_cclk_div),
      .ecfg_cclk_pllcfg (ecfg_cclk_pllcfg),
      .ecfg_coreid      (ecfg_coreid),
      .ecfg_dataout     (ecfg_dataout),
      .cfgclk           (cfgclk),
      .datain_q         (datain_q)
   );

   // ########################################################################
   // readback mux
   // ########################################################################
   ecfg_readback #(
      .RFAW      (RFAW),
      .IDW       (IDW),
      .E_VERSION (E_VERSION)
   ) u_readback (
      .mi_clk       (mi_clk),
      .hw_reset     (hw_reset),
      .mi_en        (mi_en),
      .mi_we        (mi_we),
      .mi_addr      (mi_addr),
      .sw_reset_bit (ecfg_sw_reset),  // register bit, not the ORed reset
      .cfgtx        (cfgtx),
      .cfgrx        (cfgrx),
      .cfgclk       (cfgclk),
      .coreid       (ecfg_coreid),
      .datain_q     (datain_q),
      .dataout_q    (ecfg_dataout),
      .mi_dout      (mi_dout)
   );

endmodule

`default_nettype wire

// File: source/ecfg_readback.sv
`default_nettype none

module ecfg_readback #(
   parameter int                  RFAW      = 12,
   parameter int                  IDW       = 12,
   parameter ecfg_pkg::cfg_word_t E_VERSION = 32'h0000_0000
) (
   input  wire                    mi_clk,
   input  wire                    hw_reset,
   input  wire                    mi_en,
   input  wire                    mi_we,
   input  wire [RFAW-1:0]         mi_addr,
   input  wire                    sw_reset_bit,
   input  wire ecfg_pkg::cfgtx_t  cfgtx,
   input  wire ecfg_pkg::cfgrx_t  cfgrx,
   input  wire ecfg_pkg::cfgclk_t cfgclk,
   input  wire [IDW-1:0]          coreid,
   input  wire ecfg_pkg::gpio_t   datain_q,
   input  wire ecfg_pkg::gpio_t   dataout_q,
   output ecfg_pkg::cfg_word_t    mi_dout
);

   logic [31:0]         word_idx;
   logic                rd_en;
   ecfg_pkg::cfg_word_t rd_mux;  // selected register, zero-extended

   assign word_idx = 32'(mi_addr[RFAW-1:2]);
   assign rd_en    = mi_en & ~mi_we;

   // ########################################################################
   // read select
   // ########################################################################
   always_comb begin
      case (word_idx)
         ecfg_pkg::REG_SYSRESET:
            rd_mux = {{(ecfg_pkg::WORD_W-1){1'b0}}, sw_reset_bit};
         ecfg_pkg::REG_SYSCFGTX:
            rd_mux = {{(ecfg_pkg::WORD_W-ecfg_pkg::CFGTX_W){1'b0}}, cfgtx};
         ecfg_pkg::REG_SYSCFGRX:
            rd_mux = {{(ecfg_pkg::WORD_W-ecfg_pkg::CFGRX_W){1'b0}}, cfgrx};
         ecfg_pkg::REG_SYSCFGCLK:
            rd_mux = {{(ecfg_pkg::WORD_W-ecfg_pkg::CFGCLK_W){1'b0}}, cfgclk};
         ecfg_pkg::REG_SYSCOREID:
            rd_mux = {{(ecfg_pkg::WORD_W-IDW){1'b0}}, coreid};
         ecfg_pkg::REG_SYSVERSION:
            rd_mux = E_VERSION;
         ecfg_pkg::REG_SYSDATAIN:
            rd_mux = {{(ecfg_pkg::WORD_W-ecfg_pkg::GPIO_W){1'b0}}, datain_q};
         ecfg_pkg::REG_SYSDATAOUT:
            rd_mux = {{(ecfg_pkg::WORD_W-ecfg_pkg::GPIO_W){1'b0}}, dataout_q};
         default:
            rd_mux = '0;  // unmapped
      endcase
   end

   // ########################################################################
   // pipelined readback
   // ########################################################################
   // data is valid the cycle after the read strobe, held otherwise
   always_ff @(posedge mi_clk) begin
      if (hw_reset) begin
         mi_dout <= '0;
      end else if (rd_en) begin
         mi_dout <= rd_mux;
      end
   end

endmodule

`default_nettype wire

// File: source/ecfg_io_regs.sv
`default_nettype none

module ecfg_io_regs #(
   parameter int             RFAW       = 12,
   parameter int             IDW        = 12,
   parameter logic [IDW-1:0] DEF_COREID = 12'h808
) (
   input  wire                      mi_clk,
   input  wire                      hw_reset,
   input  wire                      mi_en,
   input  wire                      mi_we,
   input  wire [RFAW-1:0]           mi_addr,
   input  wire ecfg_pkg::cfg_word_t mi_din,
   input  wire ecfg_pkg::gpio_t     ecfg_datain,
   output logic                     ecfg_cclk_en,
   output ecfg_pkg::nibble_t        ecfg_cclk_div,
   output ecfg_pkg::nibble_t        ecfg_cclk_pllcfg,
   output logic [IDW-1:0]           ecfg_coreid,
   output ecfg_pkg::gpio_t          ecfg_dataout,
   output ecfg_pkg::cfgclk_t        cfgclk,
   output ecfg_pkg::gpio_t          datain_q
);

   logic [31:0] word_idx;
   logic        wr_en;
   logic        cfgclk_wr;
   logic        coreid_wr;
   logic        dataout_wr;

   // ########################################################################
   // write decode
   // ########################################################################
   assign word_idx   = 32'(mi_addr[RFAW-1:2]);  // byte address to word index
   assign wr_en      = mi_en & mi_we;

   assign cfgclk_wr  = wr_en & (word_idx == ecfg_pkg::REG_SYSCFGCLK);
   assign coreid_wr  = wr_en & (word_idx == ecfg_pkg::REG_SYSCOREID);
   assign dataout_wr = wr_en & (word_idx == ecfg_pkg::REG_SYSDATAOUT);

   // ########################################################################
   // SYSCFGCLK
   // ########################################################################
   always_ff @(posedge mi_clk) begin
      if (hw_reset) begin
         cfgclk <= '0;
      end else if (cfgclk_wr) begin
         cfgclk <= mi_din[ecfg_pkg::CFGCLK_W-1:0];
      end
   end

   assign ecfg_cclk_div    = cfgclk[3:0];
   assign ecfg_cclk_pllcfg = cfgclk[7:4];
   assign ecfg_cclk_en     = |cfgclk[3:0];  // divider 0 means clock off

   // ########################################################################
   // SYSCOREID
   // ########################################################################
   always_ff @(posedge mi_clk) begin
      if (hw_reset) begin
         ecfg_coreid <= DEF_COREID;  // row/column of this link
      end else if (coreid_wr) begin
         ecfg_coreid <= mi_din[IDW-1:0];
      end
   end

   // ########################################################################
   // SYSDATAOUT / SYSDATAIN
   // ########################################################################
   always_ff @(posedge mi_clk) begin
      if (hw_reset) begin
         ecfg_dataout <= '0;
      end else if (dataout_wr) begin
         ecfg_dataout <= mi_din[ecfg_pkg::GPIO_W-1:0];
      end
   end

   // pins sampled every cycle
   always_ff @(posedge mi_clk) begin
      datain_q <= ecfg_datain;
   end

endmodule

`default_nettype wire

// File: source/ecfg_link_regs.sv
`default_nettype none

module ecfg_link_regs #(
   parameter int RFAW = 12
) (
   input  wire                      mi_clk,
   input  wire                      hw_reset,
   input  wire                      mi_en,
   input  wire                      mi_we,
   input  wire [RFAW-1:0]           mi_addr,
   input  wire ecfg_pkg::cfg_word_t mi_din,
   output logic                     ecfg_sw_reset,
   output logic                     ecfg_reset,
   output logic                     ecfg_tx_enable,
   output logic                     ecfg_tx_mmu_mode,
   output logic                     ecfg_tx_gpio_mode,
   output ecfg_pkg::nibble_t        ecfg_tx_ctrl_mode,
   output ecfg_pkg::nibble_t        ecfg_tx_clkdiv,
   output logic                     ecfg_rx_enable,
   output logic                     ecfg_rx_mmu_mode,
   output logic                     ecfg_rx_gpio_mode,
   output logic                     ecfg_rx_loopback_mode,
   output ecfg_pkg::cfgtx_t         cfgtx,
   output ecfg_pkg::cfgrx_t         cfgrx
);

   logic [31:0] word_idx;  // zero-extended word index
   logic        wr_en;
   logic        reset_wr;
   logic        cfgtx_wr;
   logic        cfgrx_wr;

   // ########################################################################
   // write decode
   // ########################################################################
   assign word_idx = 32'(mi_addr[RFAW-1:2]);
   assign wr_en    = mi_en & mi_we;

   assign reset_wr = wr_en & (word_idx == ecfg_pkg::REG_SYSRESET);
   assign cfgtx_wr = wr_en & (word_idx == ecfg_pkg::REG_SYSCFGTX);
   assign cfgrx_wr = wr_en & (word_idx == ecfg_pkg::REG_SYSCFGRX);

   // ########################################################################
   // SYSRESET
   // ########################################################################
   always_ff @(posedge mi_clk) begin
      if (hw_reset) begin
         ecfg_sw_reset <= 1'b0;
      end else if (reset_wr) begin
         ecfg_sw_reset <= mi_din[0];
      end
   end

   // hw reset passes straight through, no extra cycle
   assign ecfg_reset = hw_reset | ecfg_sw_reset;

   // ########################################################################
   // SYSCFGTX
   // ########################################################################
   always_ff @(posedge mi_clk) begin
      if (hw_reset) begin
         cfgtx <= '0;
      end else if (cfgtx_wr) begin
         cfgtx <= mi_din[ecfg_pkg::CFGTX_W-1:0];
      end
   end

   assign ecfg_tx_enable    = cfgtx[0];
   assign ecfg_tx_mmu_mode  = cfgtx[1];
   assign ecfg_tx_gpio_mode = (cfgtx[3:2] == 2'b01);  // pins forced to constants
   assign ecfg_tx_ctrl_mode = cfgtx[7:4];             // emesh ctrlmode tag
   assign ecfg_tx_clkdiv    = cfgtx[11:8];

   // ########################################################################
   // SYSCFGRX
   // ########################################################################
   always_ff @(posedge mi_clk) begin
      if (hw_reset) begin
         cfgrx <= '0;
      end else if (cfgrx_wr) begin
         cfgrx <= mi_din[ecfg_pkg::CFGRX_W-1:0];
      end
   end

   // bit 4 is the monitor bit, kept for readback only
   assign ecfg_rx_enable        = cfgrx[0];
   assign ecfg_rx_mmu_mode      = cfgrx[1];
   assign ecfg_rx_gpio_mode     = (cfgrx[3:2] == 2'b01);
   assign ecfg_rx_loopback_mode = (cfgrx[3:2] == 2'b10);  // tx looped to rx after serdes

endmodule

`default_nettype wire

// File: source/ecfg_pkg.sv
`default_nettype none

package ecfg_pkg;

   // ########################################################################
   // register map, word indices on mi_addr[RFAW-1:2]
   // ########################################################################
   localparam int unsigned REG_SYSRESET   = 0;  // software reset
   localparam int unsigned REG_SYSCFGTX   = 1;
   localparam int unsigned REG_SYSCFGRX   = 2;
   localparam int unsigned REG_SYSCFGCLK  = 3;
   localparam int unsigned REG_SYSCOREID  = 4;
   localparam int unsigned REG_SYSVERSION = 5;  // read only
   localparam int unsigned REG_SYSDATAIN  = 6;  // read only, sampled pins
   localparam int unsigned REG_SYSDATAOUT = 7;

   // ########################################################################
   // field widths
   // ########################################################################
   localparam int unsigned WORD_W   = 32;
   localparam int unsigned GPIO_W   = 11;  // rd_wait, wr_wait, frame, data[7:0]
   localparam int unsigned NIBBLE_W = 4;
   localparam int unsigned CFGTX_W  = 12;
   localparam int unsigned CFGRX_W  = 5;
   localparam int unsigned CFGCLK_W = 8;

   // host bus data
   typedef logic [WORD_W-1:0] cfg_word_t;

   // pin vector, msb first: rd_wait, wr_wait, frame, data
   typedef logic [GPIO_W-1:0] gpio_t;

   // ctrl mode, dividers, pll setting
   typedef logic [NIBBLE_W-1:0] nibble_t;

   // raw register contents
   typedef logic [CFGTX_W-1:0]  cfgtx_t;
   typedef logic [CFGRX_W-1:0]  cfgrx_t;
   typedef logic [CFGCLK_W-1:0] cfgclk_t;

endpackage

`default_nettype wire
